//--- design/mem_types_pkg.sv
package mem_types_pkg;

    typedef logic [31:0] word_t;

    // byte address, the memory drops the lowest two bits
    typedef logic [31:0] addr_t;

    // one bit per byte lane
    typedef logic [3:0] byte_en_t;

    // instruction fetch can only read
    typedef struct packed {
        logic  read;
        addr_t addr;
    } fetch_req_t;

    // data client and shared memory port
    typedef struct packed {
        logic     read;
        logic     write;
        addr_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } mem_req_t;

    // resp is a one-cycle pulse, rdata valid in that cycle
    typedef struct packed {
        logic  resp;
        word_t rdata;
    } mem_rsp_t;

endpackage

//--- design/arbiter_pkg.sv
package arbiter_pkg;

    // who currently owns the shared memory port
    typedef enum logic [1:0] {
        idle,
        serving_fetch,
        serving_data
    } arb_state_e;

    // select handed from controller to datapath
    typedef enum logic {
        sel_fetch,
        sel_data
    } client_sel_e;

endpackage

//--- design/arbiter_controller.sv
`timescale 1ns/10ps

module arbiter_controller (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     fetch_read,
    input  logic                     data_read,
    input  logic                     data_write,
    input  logic                     mem_resp,
    output arbiter_pkg::client_sel_e sel
);
    import arbiter_pkg::*;

    arb_state_e state;
    arb_state_e next_state;
    logic       data_pending;

    assign data_pending = data_read | data_write;

    // fetch wins from idle and each response hands over to a waiting client
    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (fetch_read)
                    next_state = serving_fetch;
                else if (data_pending)
                    next_state = serving_data;
            end
            serving_fetch: begin
                if (mem_resp)
                    next_state = data_pending ? serving_data : idle;
            end
            serving_data: begin
                if (mem_resp)
                    next_state = fetch_read ? serving_fetch : idle;
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    // in idle the select follows the inputs so the memory sees the request at once
    always_comb begin
        case (state)
            serving_fetch: sel = sel_fetch;
            serving_data:  sel = sel_data;
            default:       sel = fetch_read ? sel_fetch : sel_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // the serving state keeps the client whose request the memory took from idle
    a_sel_kept_from_idle: assert property (
        @(posedge clk) disable iff (reset)
        ((state == idle) && (next_state != idle)) |=> (sel == $past(sel))
    ) else $error("arbiter_controller: served client differs from the one selected in idle");

    // memory only answers a request the controller has handed it
    a_no_resp_in_idle: assert property (
        @(posedge clk) disable iff (reset)
        (state == idle) |-> !mem_resp
    ) else $error("arbiter_controller: memory response while idle");

    a_fetch_held: assert property (
        @(posedge clk) disable iff (reset)
        (state == serving_fetch) |-> fetch_read
    ) else $error("arbiter_controller: fetch request dropped before its response");

    a_data_held: assert property (
        @(posedge clk) disable iff (reset)
        (state == serving_data) |-> data_pending
    ) else $error("arbiter_controller: data request dropped before its response");

endmodule

//--- design/cache_arbiter.sv
`timescale 1ns/10ps

module cache_arbiter (
    input  logic                      clk,
    input  logic                      reset,
    input  mem_types_pkg::fetch_req_t fetch_req,
    output mem_types_pkg::mem_rsp_t   fetch_rsp,
    input  mem_types_pkg::mem_req_t   data_req,
    output mem_types_pkg::mem_rsp_t   data_rsp,
    output mem_types_pkg::mem_req_t   mem_req,
    input  mem_types_pkg::mem_rsp_t   mem_rsp
);
    import mem_types_pkg::*;
    import arbiter_pkg::*;

    client_sel_e sel;

    arbiter_controller controller_inst (
        .clk        (clk),
        .reset      (reset),
        .fetch_read (fetch_req.read),
        .data_read  (data_req.read),
        .data_write (data_req.write),
        .mem_resp   (mem_rsp.resp),
        .sel        (sel)
    );

    // fetch never writes on the shared port
    always_comb begin
        if (sel == sel_fetch) begin
            mem_req.read    = fetch_req.read;
            mem_req.write   = 1'b0;
            mem_req.addr    = fetch_req.addr;
            mem_req.wdata   = '0;
            mem_req.byte_en = '0;
        end else begin
            mem_req = data_req;
        end
    end

    // read data goes to both clients and the pulse only to the owner
    always_comb begin
        fetch_rsp.rdata = mem_rsp.rdata;
        data_rsp.rdata  = mem_rsp.rdata;
        fetch_rsp.resp  = mem_rsp.resp && (sel == sel_fetch);
        data_rsp.resp   = mem_rsp.resp && (sel == sel_data);
    end

    // a memory response reaches exactly one client that holds a request
    a_one_client_resp: assert property (
        @(posedge clk) disable iff (reset)
        mem_rsp.resp |-> $onehot({fetch_rsp.resp && fetch_req.read,
                                  data_rsp.resp && (data_req.read || data_req.write)})
    ) else $error("cache_arbiter: response pulse not routed to exactly one requesting client");

endmodule

//--- design/backing_memory.sv
`timescale 1ns/10ps

module backing_memory #(
    parameter int mem_words   = 1024,
    parameter int mem_latency = 3
) (
    input  logic                    clk,
    input  logic                    reset,
    input  mem_types_pkg::mem_req_t mem_req,
    output mem_types_pkg::mem_rsp_t mem_rsp
);
    import mem_types_pkg::*;

    localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;
    localparam int cnt_w = (mem_latency > 1) ? $clog2(mem_latency) : 1;

    typedef enum logic [1:0] {
        idle,
        busy,
        respond
    } mem_state_e;

    if (mem_latency < 1) begin : g_bad_latency
        $error("backing_memory: mem_latency must be at least 1");
    end

    mem_state_e       state;
    logic [cnt_w-1:0] cnt;
    logic             accept;
    logic             done;
    logic [29:0]      word_addr;

    logic [idx_w-1:0] idx_q;
    logic             write_q;
    word_t            wdata_q;
    byte_en_t         byte_en_q;
    word_t            rdata_q;

    word_t mem [mem_words];

    assign accept = (state == idle) && (mem_req.read || mem_req.write);

    // last busy cycle, the next edge raises the pulse
    assign done = (state == busy) && (cnt == cnt_w'(mem_latency - 1));

    // word index wraps modulo the depth
    assign word_addr = mem_req.addr[31:2] % 30'(mem_words);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            cnt   <= '0;
        end else begin
            case (state)
                idle: begin
                    if (accept) begin
                        state <= busy;
                        cnt   <= '0;
                    end
                end
                busy: begin
                    if (done)
                        state <= respond;
                    else
                        cnt <= cnt + 1'b1;
                end
                // one idle cycle follows so a held request is not taken again
                respond: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q     <= word_addr[idx_w-1:0];
            write_q   <= mem_req.write;
            wdata_q   <= mem_req.wdata;
            byte_en_q <= mem_req.byte_en;
        end
    end

    // write lands on the response edge, only enabled lanes change
    always_ff @(posedge clk) begin
        if (done) begin
            rdata_q <= mem[idx_q];
            if (write_q) begin
                for (int i = 0; i < 4; i++) begin
                    if (byte_en_q[i])
                        mem[idx_q][8*i +: 8] <= wdata_q[8*i +: 8];
                end
            end
        end
    end

    assign mem_rsp.resp  = (state == respond);
    assign mem_rsp.rdata = rdata_q;

    a_no_read_write: assert property (
        @(posedge clk) disable iff (reset)
        !(mem_req.read && mem_req.write)
    ) else $error("backing_memory: read and write high together");

    a_write_has_lanes: assert property (
        @(posedge clk) disable iff (reset)
        mem_req.write |-> (mem_req.byte_en != '0)
    ) else $error("backing_memory: write with no byte lane enabled");

endmodule

//--- design/mem_subsystem_top.sv
`timescale 1ns/10ps

module mem_subsystem_top #(
    parameter int mem_words   = 1024,
    parameter int mem_latency = 3
) (
    input  logic                      clk,
    input  logic                      reset,
    input  mem_types_pkg::fetch_req_t fetch_req,
    output mem_types_pkg::mem_rsp_t   fetch_rsp,
    input  mem_types_pkg::mem_req_t   data_req,
    output mem_types_pkg::mem_rsp_t   data_rsp
);
    import mem_types_pkg::*;

    // shared port between arbiter and memory
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    cache_arbiter cache_arbiter_inst (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    backing_memory #(
        .mem_words   (mem_words),
        .mem_latency (mem_latency)
    ) backing_memory_inst (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

//--- tests/mem_subsystem_tb.sv
`timescale 1ns/10ps

module mem_subsystem_tb;
    import mem_types_pkg::*;

    localparam int mem_words      = 1024;
    localparam int timeout_cycles = 20000;
    localparam int pool_words     = 16;
    // 100 operations per client make 200 in total
    localparam int mix_ops        = 100;

    logic       clk;
    logic       reset;
    fetch_req_t fetch_req;
    mem_rsp_t   fetch_rsp;
    mem_req_t   data_req;
    mem_rsp_t   data_rsp;

    int    errors;
    int    cycle_count;
    int    fetch_resp_cycle;
    int    data_resp_cycle;
    word_t shadow [int];
    addr_t written_addrs [$];

    mem_subsystem_top mem_subsystem_top_inst (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, a request never completed, errors: %0d",
                 cycle_count, errors);
        $display("STATUS: FAIL");
        $finish;
    end

    // a pulse with no request behind it went to the wrong client
    always @(negedge clk) begin
        if (!reset) begin
            if (fetch_rsp.resp && !fetch_req.read) begin
                $display("ERROR: fetch response pulse while the fetch client had no request");
                errors++;
            end
            if (data_rsp.resp && !(data_req.read || data_req.write)) begin
                $display("ERROR: data response pulse while the data client had no request");
                errors++;
            end
        end
    end

    // word index wraps modulo the memory depth
    function automatic int word_index(addr_t addr);
        return int'((addr >> 2) % mem_words);
    endfunction

    function automatic word_t merge_lanes(word_t old_word, word_t new_word, byte_en_t be);
        word_t result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i])
                result[8*i +: 8] = new_word[8*i +: 8];
        end
        return result;
    endfunction

    function automatic word_t shadow_word(addr_t addr);
        if (shadow.exists(word_index(addr)))
            return shadow[word_index(addr)];
        return 'x;
    endfunction

    task automatic report_mismatch(string test_name, word_t expected, word_t actual);
        $display("FAIL %s: expected %h, actual %h", test_name, expected, actual);
        errors++;
    endtask

    task automatic fetch_read(input addr_t addr, output word_t rdata);
        @(posedge clk);
        #1;
        fetch_req.read = 1'b1;
        fetch_req.addr = addr;
        do begin
            @(negedge clk);
        end while (!fetch_rsp.resp);
        rdata = fetch_rsp.rdata;
        fetch_resp_cycle = cycle_count;
        @(posedge clk);
        #1;
        fetch_req = '0;
    endtask

    task automatic data_read(input addr_t addr, output word_t rdata);
        @(posedge clk);
        #1;
        data_req = '0;
        data_req.read = 1'b1;
        data_req.addr = addr;
        do begin
            @(negedge clk);
        end while (!data_rsp.resp);
        rdata = data_rsp.rdata;
        data_resp_cycle = cycle_count;
        @(posedge clk);
        #1;
        data_req = '0;
    endtask

    // shadow changes at the response just as the memory word does
    task automatic data_write(input addr_t addr, input word_t wdata, input byte_en_t be);
        @(posedge clk);
        #1;
        data_req.read    = 1'b0;
        data_req.write   = 1'b1;
        data_req.addr    = addr;
        data_req.wdata   = wdata;
        data_req.byte_en = be;
        do begin
            @(negedge clk);
        end while (!data_rsp.resp);
        shadow[word_index(addr)] = merge_lanes(shadow_word(addr), wdata, be);
        data_resp_cycle = cycle_count;
        @(posedge clk);
        #1;
        data_req = '0;
    endtask

    task automatic test_reset();
        repeat (8) begin
            @(negedge clk);
            if (fetch_rsp.resp !== 1'b0 || data_rsp.resp !== 1'b0) begin
                $display("ERROR: test_reset saw a response pulse that was not low after reset");
                errors++;
            end
        end
    endtask

    task automatic test_data_write_read();
        word_t rdata;
        addr_t addr;
        for (int i = 0; i < 8; i++) begin
            addr = 32'h100 + 32'(i * 12);
            data_write(addr, $urandom(), 4'hf);
            written_addrs.push_back(addr);
        end
        // an address beyond the depth wraps to index 4
        data_write(32'h0000_1010, 32'hcafe_f00d, 4'hf);
        written_addrs.push_back(32'h0000_0010);
        foreach (written_addrs[i]) begin
            data_read(written_addrs[i], rdata);
            if (rdata !== shadow_word(written_addrs[i]))
                report_mismatch("test_data_write_read", shadow_word(written_addrs[i]), rdata);
        end
    endtask

    task automatic test_byte_enable();
        byte_en_t patterns [6];
        word_t    rdata;
        addr_t    addr;
        patterns = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0110, 4'b1011};
        addr = 32'h240;
        data_write(addr, 32'h1122_3344, 4'hf);
        foreach (patterns[i]) begin
            data_write(addr, $urandom(), patterns[i]);
            data_read(addr, rdata);
            if (rdata !== shadow_word(addr))
                report_mismatch("test_byte_enable", shadow_word(addr), rdata);
        end
    endtask

    task automatic test_fetch_read();
        word_t rdata;
        foreach (written_addrs[i]) begin
            fetch_read(written_addrs[i], rdata);
            if (rdata !== shadow_word(written_addrs[i]))
                report_mismatch("test_fetch_read", shadow_word(written_addrs[i]), rdata);
        end
    endtask

    task automatic test_contention();
        word_t rdata_f;
        word_t rdata_d;
        fork
            fetch_read(written_addrs[0], rdata_f);
            data_read(written_addrs[1], rdata_d);
        join
        if (fetch_resp_cycle >= data_resp_cycle) begin
            $display("ERROR: test_contention served the data client before the fetch client");
            errors++;
        end
        if (rdata_f !== shadow_word(written_addrs[0]))
            report_mismatch("test_contention fetch", shadow_word(written_addrs[0]), rdata_f);
        if (rdata_d !== shadow_word(written_addrs[1]))
            report_mismatch("test_contention data", shadow_word(written_addrs[1]), rdata_d);
    endtask

    task automatic test_random_mix();
        addr_t    fetch_addrs [mix_ops];
        int       fetch_gaps [mix_ops];
        addr_t    data_addrs [mix_ops];
        word_t    data_wdata [mix_ops];
        byte_en_t data_be [mix_ops];
        logic     data_is_write [mix_ops];
        int       data_gaps [mix_ops];
        addr_t    base;
        base = 32'h800;
        for (int i = 0; i < pool_words; i++)
            data_write(base + 32'(4 * i), $urandom(), 4'hf);
        // all stimulus drawn up front so the two clients never race for $urandom
        for (int i = 0; i < mix_ops; i++) begin
            fetch_addrs[i]   = base + 32'(4 * $urandom_range(pool_words - 1, 0));
            fetch_gaps[i]    = $urandom_range(3, 0);
            data_addrs[i]    = base + 32'(4 * $urandom_range(pool_words - 1, 0));
            data_wdata[i]    = $urandom();
            data_be[i]       = byte_en_t'($urandom_range(15, 1));
            data_is_write[i] = $urandom_range(1, 0);
            data_gaps[i]     = $urandom_range(3, 0);
        end
        fork
            begin : fetch_side
                word_t rdata;
                for (int i = 0; i < mix_ops; i++) begin
                    repeat (fetch_gaps[i]) @(posedge clk);
                    fetch_read(fetch_addrs[i], rdata);
                    if (rdata !== shadow_word(fetch_addrs[i]))
                        report_mismatch("test_random_mix fetch", shadow_word(fetch_addrs[i]),
                                        rdata);
                end
            end
            begin : data_side
                word_t rdata;
                for (int i = 0; i < mix_ops; i++) begin
                    repeat (data_gaps[i]) @(posedge clk);
                    if (data_is_write[i]) begin
                        data_write(data_addrs[i], data_wdata[i], data_be[i]);
                    end else begin
                        data_read(data_addrs[i], rdata);
                        if (rdata !== shadow_word(data_addrs[i]))
                            report_mismatch("test_random_mix data", shadow_word(data_addrs[i]),
                                            rdata);
                    end
                end
            end
        join
    endtask

    initial begin
        errors    = 0;
        reset     = 1'b1;
        fetch_req = '0;
        data_req  = '0;
        void'($urandom(32'h9e95));
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset();
        test_data_write_read();
        test_byte_enable();
        test_fetch_read();
        test_contention();
        test_random_mix();

        repeat (5) @(posedge clk);
        $display("tests done after %0d cycles, errors: %0d", cycle_count, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
design/mem_types_pkg.sv
design/arbiter_pkg.sv
design/arbiter_controller.sv
design/cache_arbiter.sv
design/backing_memory.sv
design/mem_subsystem_top.sv
tests/mem_subsystem_tb.sv
